/* compile.f */
+incdir+hw
hw/wb_pkg.sv
hw/fifo.sv
hw/ex_queue.sv
hw/wb_arbiter.sv
hw/wb_subsystem.sv
verification/wb_checker.sv
verification/wb_tb.sv

/* hw/ex_queue.sv */
////////////////////////////////////////////////////////////////////////////
// execute result queue
// packs one lane's result and bypasses it when empty, else buffers it.
////////////////////////////////////////////////////////////////////////////

`include "wb_defines.svh"

module ex_queue import wb_pkg::*; #(
  parameter int depth = 4
) (
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          in_val,
  output logic                          in_rdy,
  input  logic [`WB_PC_BITS-1:0]        in_pc,
  input  logic [`WB_ARCH_ADDR_BITS-1:0] in_waddr,
  input  logic [`WB_DATA_BITS-1:0]      in_wdata,
  input  logic                          in_wen,
  input  seq_num_t                      in_seq_num,
  input  preg_t                         in_preg,
  input  preg_t                         in_ppreg,

  output logic                          out_val,
  input  logic                          out_rdy,
  output wb_msg_t                       out_msg
);

  wb_msg_t in_msg;      // packed lane input.
  wb_msg_t buf_head;    // fifo head entry.
  logic    buf_push;
  logic    buf_pop;
  logic    buf_empty;
  logic    buf_full;
  logic    bypass;      // input goes straight out.

  ////////////////////////////////////////////////////////////////////////////
  // pack loose fields
  ////////////////////////////////////////////////////////////////////////////

  assign in_msg.pc      = in_pc;
  assign in_msg.waddr   = in_waddr;
  assign in_msg.wdata   = in_wdata;
  assign in_msg.wen     = in_wen;
  assign in_msg.seq_num = in_seq_num;
  assign in_msg.preg    = in_preg;
  assign in_msg.ppreg   = in_ppreg;

  ////////////////////////////////////////////////////////////////////////////
  // buffer
  ////////////////////////////////////////////////////////////////////////////

  fifo #(
    .entry_bits ($bits(wb_msg_t)),
    .depth      (depth)
  ) buf_i (
    .clk   (clk),
    .reset (reset),
    .push  (buf_push),
    .pop   (buf_pop),
    .wdata (in_msg),
    .rdata (buf_head),
    .empty (buf_empty),
    .full  (buf_full)
  );

  ////////////////////////////////////////////////////////////////////////////
  // bypass and handshake
  ////////////////////////////////////////////////////////////////////////////

  assign bypass  = buf_empty;                          // nothing older waits.
  assign out_msg = bypass ? in_msg : buf_head;         // oldest result first.
  assign out_val = ~buf_empty | in_val;                // head or live input.
  assign in_rdy  = ~buf_full | out_rdy;                // room, or one leaves.

  // store unless it went straight through this cycle.
  assign buf_push = in_val & in_rdy & ~(bypass & out_rdy);
  assign buf_pop  = ~buf_empty & out_rdy;              // head accepted.

endmodule

/* hw/fifo.sv */
////////////////////////////////////////////////////////////////////////////
// fifo
// circular buffer with occupancy count; push and pop may share a cycle,
// even when the buffer is full.
////////////////////////////////////////////////////////////////////////////

module fifo #(
  parameter int entry_bits = 8,
  parameter int depth      = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push,
  input  logic                  pop,
  input  logic [entry_bits-1:0] wdata,
  output logic [entry_bits-1:0] rdata,
  output logic                  empty,
  output logic                  full
);

  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_bits = $clog2(depth + 1);

  logic [entry_bits-1:0] mem [depth];  // storage, no reset.
  logic [ptr_bits-1:0]   rd_ptr;       // head slot.
  logic [ptr_bits-1:0]   wr_ptr;       // next free slot.
  logic [cnt_bits-1:0]   count;        // live entries.
  logic                  do_push;
  logic                  do_pop;

  // wrap at depth, which need not be a power of two.
  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    logic [ptr_bits-1:0] nxt;
    if (ptr == ptr_bits'(depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign empty   = (count == '0);                 // nothing stored.
  assign full    = (count == cnt_bits'(depth));   // every slot used.
  assign do_pop  = pop & ~empty;                  // ignore pop on empty.
  assign do_push = push & (~full | do_pop);       // full only with pop.
  assign rdata   = mem[rd_ptr];                   // head always visible.

  ////////////////////////////////////////////////////////////////////////////
  // storage write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;  // write at tail.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);  // advance tail.
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);  // advance head.
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;  // push only.
        2'b01:   count <= count - 1'b1;  // pop only.
        default: count <= count;         // both or neither.
      endcase
    end
  end

endmodule

/* hw/wb_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// writeback arbiter
// round-robin pick of one lane per cycle onto the writeback port.
////////////////////////////////////////////////////////////////////////////

`include "wb_defines.svh"

module wb_arbiter import wb_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          alu_val,
  input  wb_msg_t                       alu_msg,
  output logic                          alu_rdy,

  input  logic                          mul_val,
  input  wb_msg_t                       mul_msg,
  output logic                          mul_rdy,

  output logic                          wb_val,
  input  logic                          wb_rdy,
  output logic [`WB_PC_BITS-1:0]        wb_pc,
  output logic [`WB_ARCH_ADDR_BITS-1:0] wb_waddr,
  output logic [`WB_DATA_BITS-1:0]      wb_wdata,
  output logic                          wb_wen,
  output seq_num_t                      wb_seq_num,
  output preg_t                         wb_preg,
  output preg_t                         wb_ppreg
);

  lane_t   last_winner;  // lane granted on last transfer.
  lane_t   grant;        // lane granted this cycle.
  wb_msg_t sel_msg;      // granted lane's message.
  logic    wb_fire;      // writeback transfer.

  ////////////////////////////////////////////////////////////////////////////
  // grant
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (alu_val && mul_val) begin
      // tie goes to the lane that did not win last.
      grant = (last_winner == LANE_ALU) ? LANE_MUL : LANE_ALU;
    end else if (alu_val) begin
      grant = LANE_ALU;   // only alu waiting.
    end else begin
      grant = LANE_MUL;   // mul waiting, or idle.
    end
  end

  assign wb_val  = alu_val | mul_val;                 // any lane ready.
  assign wb_fire = wb_val & wb_rdy;
  assign alu_rdy = wb_rdy & (grant == LANE_ALU);      // granted lane only.
  assign mul_rdy = wb_rdy & (grant == LANE_MUL);

  ////////////////////////////////////////////////////////////////////////////
  // message mux and unpack
  ////////////////////////////////////////////////////////////////////////////

  assign sel_msg = (grant == LANE_ALU) ? alu_msg : mul_msg;

  assign wb_pc      = sel_msg.pc;
  assign wb_waddr   = sel_msg.waddr;
  assign wb_wdata   = sel_msg.wdata;
  assign wb_wen     = sel_msg.wen;
  assign wb_seq_num = sel_msg.seq_num;
  assign wb_preg    = sel_msg.preg;
  assign wb_ppreg   = sel_msg.ppreg;

  ////////////////////////////////////////////////////////////////////////////
  // priority pointer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      last_winner <= LANE_MUL;    // alu wins first tie.
    end else if (wb_fire) begin
      last_winner <= grant;       // only on completed transfer.
    end
  end

endmodule

/* hw/wb_defines.svh */
////////////////////////////////////////////////////////////////////////////
// writeback sizing macros
// field widths, queue depth and lane count for the result path.
////////////////////////////////////////////////////////////////////////////

`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

`define WB_PC_BITS         32  // program counter width.
`define WB_ARCH_ADDR_BITS  5   // architectural register index.
`define WB_DATA_BITS       32  // result data width.
`define WB_SEQ_NUM_BITS    6   // instruction sequence number.
`define WB_PHYS_ADDR_BITS  6   // physical register index.

`define WB_QUEUE_DEPTH     4   // entries per execute queue.
`define WB_NUM_LANES       2   // alu and multiplier.

`endif

/* hw/wb_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// writeback package
// result message layout and source lane naming for the writeback side.
////////////////////////////////////////////////////////////////////////////

`include "wb_defines.svh"

package wb_pkg;

  typedef logic [`WB_SEQ_NUM_BITS-1:0]   seq_num_t;  // instruction age tag.
  typedef logic [`WB_PHYS_ADDR_BITS-1:0] preg_t;     // physical register index.

  //////////////////////////////////////////////////////////////////////////
  // result message, 88 bits, pc in the top bits
  //////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`WB_PC_BITS-1:0]        pc;       // pc of producing instr.
    logic [`WB_ARCH_ADDR_BITS-1:0] waddr;    // arch destination.
    logic [`WB_DATA_BITS-1:0]      wdata;    // result value.
    logic                          wen;      // writes a register.
    seq_num_t                      seq_num;  // age tag.
    preg_t                         preg;     // new physical dest.
    preg_t                         ppreg;    // previous mapping.
  } wb_msg_t;

  //////////////////////////////////////////////////////////////////////////
  // source lane, also the arbiter pointer
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [$clog2(`WB_NUM_LANES)-1:0] {
    LANE_ALU,  // integer alu lane.
    LANE_MUL   // multiplier lane.
  } lane_t;

endpackage

/* hw/wb_subsystem.sv */
////////////////////////////////////////////////////////////////////////////
// writeback subsystem
// alu and multiplier result queues merged onto one writeback port.
////////////////////////////////////////////////////////////////////////////

`include "wb_defines.svh"

module wb_subsystem import wb_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,

  // alu lane.
  input  logic                          alu_val,
  output logic                          alu_rdy,
  input  logic [`WB_PC_BITS-1:0]        alu_pc,
  input  logic [`WB_ARCH_ADDR_BITS-1:0] alu_waddr,
  input  logic [`WB_DATA_BITS-1:0]      alu_wdata,
  input  logic                          alu_wen,
  input  seq_num_t                      alu_seq_num,
  input  preg_t                         alu_preg,
  input  preg_t                         alu_ppreg,

  // multiplier lane.
  input  logic                          mul_val,
  output logic                          mul_rdy,
  input  logic [`WB_PC_BITS-1:0]        mul_pc,
  input  logic [`WB_ARCH_ADDR_BITS-1:0] mul_waddr,
  input  logic [`WB_DATA_BITS-1:0]      mul_wdata,
  input  logic                          mul_wen,
  input  seq_num_t                      mul_seq_num,
  input  preg_t                         mul_preg,
  input  preg_t                         mul_ppreg,

  // writeback port.
  output logic                          wb_val,
  input  logic                          wb_rdy,
  output logic [`WB_PC_BITS-1:0]        wb_pc,
  output logic [`WB_ARCH_ADDR_BITS-1:0] wb_waddr,
  output logic [`WB_DATA_BITS-1:0]      wb_wdata,
  output logic                          wb_wen,
  output seq_num_t                      wb_seq_num,
  output preg_t                         wb_preg,
  output preg_t                         wb_ppreg
);

  logic    alu_q_val;   // alu queue has a result.
  logic    alu_q_rdy;   // arbiter takes alu result.
  wb_msg_t alu_q_msg;
  logic    mul_q_val;   // mul queue has a result.
  logic    mul_q_rdy;   // arbiter takes mul result.
  wb_msg_t mul_q_msg;

  ////////////////////////////////////////////////////////////////////////////
  // per-lane queues
  ////////////////////////////////////////////////////////////////////////////

  ex_queue #(.depth(`WB_QUEUE_DEPTH)) alu_queue_i (
    .clk        (clk),
    .reset      (reset),
    .in_val     (alu_val),
    .in_rdy     (alu_rdy),
    .in_pc      (alu_pc),
    .in_waddr   (alu_waddr),
    .in_wdata   (alu_wdata),
    .in_wen     (alu_wen),
    .in_seq_num (alu_seq_num),
    .in_preg    (alu_preg),
    .in_ppreg   (alu_ppreg),
    .out_val    (alu_q_val),
    .out_rdy    (alu_q_rdy),
    .out_msg    (alu_q_msg)
  );

  ex_queue #(.depth(`WB_QUEUE_DEPTH)) mul_queue_i (
    .clk        (clk),
    .reset      (reset),
    .in_val     (mul_val),
    .in_rdy     (mul_rdy),
    .in_pc      (mul_pc),
    .in_waddr   (mul_waddr),
    .in_wdata   (mul_wdata),
    .in_wen     (mul_wen),
    .in_seq_num (mul_seq_num),
    .in_preg    (mul_preg),
    .in_ppreg   (mul_ppreg),
    .out_val    (mul_q_val),
    .out_rdy    (mul_q_rdy),
    .out_msg    (mul_q_msg)
  );

  ////////////////////////////////////////////////////////////////////////////
  // merge onto writeback
  ////////////////////////////////////////////////////////////////////////////

  wb_arbiter arbiter_i (
    .clk        (clk),
    .reset      (reset),
    .alu_val    (alu_q_val),
    .alu_msg    (alu_q_msg),
    .alu_rdy    (alu_q_rdy),
    .mul_val    (mul_q_val),
    .mul_msg    (mul_q_msg),
    .mul_rdy    (mul_q_rdy),
    .wb_val     (wb_val),
    .wb_rdy     (wb_rdy),
    .wb_pc      (wb_pc),
    .wb_waddr   (wb_waddr),
    .wb_wdata   (wb_wdata),
    .wb_wen     (wb_wen),
    .wb_seq_num (wb_seq_num),
    .wb_preg    (wb_preg),
    .wb_ppreg   (wb_ppreg)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the writeback testbench with verilator, run it, check the log.
set -u
cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="$build_dir/sim.log"
mkdir -p "$build_dir" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module wb_tb \
  -Mdir "$build_dir/obj_dir" -o wb_sim > "$build_dir/build.log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_dir/build.log"
  echo "verilator build failed"
  exit 1
fi

"$build_dir/obj_dir/wb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1

/* verification/wb_checker.sv */
////////////////////////////////////////////////////////////////////////////
// writeback checker
// scoreboard on the subsystem ports. models both lane queues and the
// round-robin pointer, compares each writeback and counts per test.
////////////////////////////////////////////////////////////////////////////

`include "wb_defines.svh"

module wb_checker import wb_pkg::*; (
  input logic                          clk,
  input logic                          reset,
  input logic                          alu_val, alu_rdy, mul_val, mul_rdy, wb_val, wb_rdy,
  input logic                          alu_wen, mul_wen, wb_wen,
  input logic [`WB_PC_BITS-1:0]        alu_pc, mul_pc, wb_pc,
  input logic [`WB_ARCH_ADDR_BITS-1:0] alu_waddr, mul_waddr, wb_waddr,
  input logic [`WB_DATA_BITS-1:0]      alu_wdata, mul_wdata, wb_wdata,
  input seq_num_t                      alu_seq_num, mul_seq_num, wb_seq_num,
  input preg_t                         alu_preg, mul_preg, wb_preg,
  input preg_t                         alu_ppreg, mul_ppreg, wb_ppreg
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int depth          = `WB_QUEUE_DEPTH;
  localparam int kind_bypass    = 0;  // zero-latency pass.
  localparam int kind_fill      = 1;  // full queue swaps one in, one out.
  localparam int kind_alternate = 2;  // tie between lanes.
  localparam int kind_stream    = 3;  // any writeback.

  int      pass_count    = 0;
  int      fail_count    = 0;
  int      errors        = 0;              // errors in current test.
  int      pending_count = 0;              // accepted, not yet written back.
  int      kind          = 0;
  int      hits [4]      = '{default: 0};  // behavior hits per kind.
  string   name          = "";
  lane_t   last_lane;                      // arbiter pointer model.
  lane_t   want;                           // lane that must win now.
  logic    alu_has;
  logic    mul_has;
  logic    fire;
  wb_msg_t got;
  wb_msg_t expected;
  wb_msg_t alu_exp [$];                    // alu items in flight.
  wb_msg_t mul_exp [$];                    // mul items in flight.

  task automatic flag_error(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic begin_test(input string test_name, input int test_kind);
    name   = test_name;
    kind   = test_kind;
    errors = 0;
    hits   = '{default: 0};
  endtask

  task automatic end_test();
    if (pending_count != 0) begin
      $display("test %s: %0d items were never written back", name, pending_count);
      errors++;
    end
    if (hits[kind] == 0) begin
      $display("test %s: the behavior under test never happened", name);
      errors++;
    end
    if (errors == 0) pass_count++;
    else fail_count++;
    $display("test %-12s %-6s errors %0d, hits %0d", name,
             (errors == 0) ? "ok" : "failed", errors, hits[kind]);
  endtask

  task automatic report();
    $display("summary: %0d passed, %0d failed", pass_count, fail_count);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // per-cycle model and compare
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      last_lane = LANE_MUL;  // alu wins first tie.
      alu_exp.delete();
      mul_exp.delete();
      pending_count = 0;
    end else begin
      alu_has = alu_val || (alu_exp.size() != 0);  // head or live input.
      mul_has = mul_val || (mul_exp.size() != 0);
      if (alu_has && mul_has) begin
        want = (last_lane == LANE_ALU) ? LANE_MUL : LANE_ALU;  // other lane.
      end else begin
        want = alu_has ? LANE_ALU : LANE_MUL;
      end
      fire = wb_val && wb_rdy;
      if (wb_val !== (alu_has || mul_has)) flag_error("wb_val disagrees with pending items");
      if (alu_rdy !== ((alu_exp.size() < depth) || (wb_rdy && want == LANE_ALU)))
        flag_error("alu_rdy disagrees with queue fill and grant");
      if (mul_rdy !== ((mul_exp.size() < depth) || (wb_rdy && want == LANE_MUL)))
        flag_error("mul_rdy disagrees with queue fill and grant");
      // behavior hits, taken before the queues move.
      if (fire && alu_val && alu_rdy && alu_exp.size() == 0 && want == LANE_ALU)
        hits[kind_bypass]++;
      if (fire && alu_val && alu_exp.size() == depth && want == LANE_ALU) hits[kind_fill]++;
      if (fire && mul_val && mul_exp.size() == depth && want == LANE_MUL) hits[kind_fill]++;
      if (fire && alu_has && mul_has) hits[kind_alternate]++;
      if (fire) hits[kind_stream]++;
      // accepts go in first, so a bypassed item is the head below.
      if (alu_val && alu_rdy)
        alu_exp.push_back({alu_pc, alu_waddr, alu_wdata, alu_wen, alu_seq_num, alu_preg,
                           alu_ppreg});
      if (mul_val && mul_rdy)
        mul_exp.push_back({mul_pc, mul_waddr, mul_wdata, mul_wen, mul_seq_num, mul_preg,
                           mul_ppreg});
      if (fire) begin
        got = {wb_pc, wb_waddr, wb_wdata, wb_wen, wb_seq_num, wb_preg, wb_ppreg};
        if (want == LANE_ALU && alu_exp.size() != 0) begin
          expected = alu_exp.pop_front();
        end else if (want == LANE_MUL && mul_exp.size() != 0) begin
          expected = mul_exp.pop_front();
        end else begin
          expected = got;
          flag_error($sformatf("writeback seq %0d with nothing pending", wb_seq_num));
        end
        if (got !== expected)
          flag_error($sformatf("%s writeback got seq %0d (%h), expected seq %0d (%h)",
                               want.name(), got.seq_num, got, expected.seq_num, expected));
        last_lane = want;  // pointer moves on transfer only.
      end
      pending_count = alu_exp.size() + mul_exp.size();
    end
  end

endmodule

/* verification/wb_tb.sv */
////////////////////////////////////////////////////////////////////////////
// writeback subsystem testbench
// table-driven traffic on both execute lanes, watchdog and final verdict.
////////////////////////////////////////////////////////////////////////////

`include "wb_defines.svh"

module wb_tb import wb_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_tests       = 6;
  localparam int mode_always     = 0;  // wb_rdy held high.
  localparam int mode_until_full = 1;  // wb_rdy low until lanes stall.
  localparam int mode_random     = 2;  // random wb_rdy and lane valids.
  localparam int kind_bypass     = 0;
  localparam int kind_fill       = 1;
  localparam int kind_alternate  = 2;
  localparam int kind_stream     = 3;
  localparam int drain_limit     = 4 * `WB_QUEUE_DEPTH + 8;  // cycles to empty both queues.

  logic                          clk;
  logic                          reset;
  logic                          alu_val, alu_rdy, mul_val, mul_rdy, wb_val, wb_rdy;
  logic                          alu_wen, mul_wen, wb_wen;
  logic [`WB_PC_BITS-1:0]        alu_pc, mul_pc, wb_pc;
  logic [`WB_ARCH_ADDR_BITS-1:0] alu_waddr, mul_waddr, wb_waddr;
  logic [`WB_DATA_BITS-1:0]      alu_wdata, mul_wdata, wb_wdata;
  seq_num_t                      alu_seq_num, mul_seq_num, wb_seq_num;
  preg_t                         alu_preg, mul_preg, wb_preg;
  preg_t                         alu_ppreg, mul_ppreg, wb_ppreg;

  string test_name [num_tests];
  int    alu_items [num_tests];
  int    mul_items [num_tests];
  int    rdy_mode  [num_tests];
  int    test_kind [num_tests];

  int seed;                // $random state.
  int next_seq;            // running item number.
  int timeout_cycles = 0;
  bit lane_done [2];       // lane driver finished.

  always #4 clk = ~clk;  // 8 ns period.

  wb_subsystem dut_i (.*);
  wb_checker checker_i (.*);

  task automatic add_row(input int i, input string n, input int a, input int m,
                         input int mode, input int kind);
    test_name[i] = n;
    alu_items[i] = a;
    mul_items[i] = m;
    rdy_mode[i]  = mode;
    test_kind[i] = kind;
  endtask

  // item fields are mixes of the running number.
  function automatic wb_msg_t make_item(input int n);
    wb_msg_t m;
    m.pc      = 32'h0000_1000 + 32'(4 * n);  // base plus four per item.
    m.waddr   = 5'(n * 3 + 1);
    m.wdata   = (32'(n) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    m.wen     = n[0] ^ n[2];
    m.seq_num = seq_num_t'(n);
    m.preg    = preg_t'(n * 7 + 3);
    m.ppreg   = preg_t'(n ^ 42);
    return m;
  endfunction

  // one lane, val held until accepted.
  task automatic drive_lane(input lane_t lane, input int count, input int mode);
    int   sent;
    logic busy;
    logic accepted;
    sent = 0;
    while (sent < count) begin
      busy = (lane == LANE_ALU) ? alu_val : mul_val;
      if (!busy && (mode != mode_random || ($random(seed) & 1) != 0)) begin
        if (lane == LANE_ALU) begin
          {alu_pc, alu_waddr, alu_wdata, alu_wen, alu_seq_num, alu_preg, alu_ppreg} =
            make_item(next_seq);
          alu_val = 1'b1;
        end else begin
          {mul_pc, mul_waddr, mul_wdata, mul_wen, mul_seq_num, mul_preg, mul_ppreg} =
            make_item(next_seq);
          mul_val = 1'b1;
        end
        next_seq++;
      end
      @(posedge clk);
      accepted = (lane == LANE_ALU) ? (alu_val && alu_rdy) : (mul_val && mul_rdy);
      @(negedge clk);
      if (accepted) begin
        sent++;
        if (lane == LANE_ALU) alu_val = 1'b0;
        else mul_val = 1'b0;
      end
    end
    lane_done[lane] = 1'b1;
  endtask

  task automatic drive_ready(input int mode);
    logic stalled;
    wb_rdy = (mode == mode_always);
    while (!(lane_done[0] && lane_done[1])) begin
      @(posedge clk);
      stalled = (lane_done[0] || (alu_val && !alu_rdy)) &&
                (lane_done[1] || (mul_val && !mul_rdy));  // queues full.
      @(negedge clk);
      if (mode == mode_random) wb_rdy = ($random(seed) & 1) != 0;
      else if (stalled) wb_rdy = 1'b1;
    end
    wb_rdy = 1'b1;
  endtask

  task automatic run_row(input int i);
    int waited;
    checker_i.begin_test(test_name[i], test_kind[i]);
    lane_done[0] = 1'b0;
    lane_done[1] = 1'b0;
    fork
      drive_lane(LANE_ALU, alu_items[i], rdy_mode[i]);
      drive_lane(LANE_MUL, mul_items[i], rdy_mode[i]);
      drive_ready(rdy_mode[i]);
    join
    wb_rdy = 1'b1;  // drain.
    waited = 0;
    while (checker_i.pending_count != 0 && waited < drain_limit) begin
      @(negedge clk);
      waited++;
    end
    repeat (2) @(negedge clk);
    checker_i.end_test();
  endtask

  initial begin : watchdog
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("watchdog: simulation hung, no end after %0d cycles", timeout_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int total;
    seed     = 32'h7a2d_dc91;
    next_seq = 0;
    clk      = 1'b0;
    reset    = 1'b1;
    wb_rdy   = 1'b0;
    {alu_val, alu_pc, alu_waddr, alu_wdata, alu_wen, alu_seq_num, alu_preg, alu_ppreg} = '0;
    {mul_val, mul_pc, mul_waddr, mul_wdata, mul_wen, mul_seq_num, mul_preg, mul_ppreg} = '0;
    // alternate first, so the first tie after reset goes to the alu.
    add_row(0, "alternate", 6, 6, mode_until_full, kind_alternate);
    add_row(1, "bypass", 1, 0, mode_always, kind_bypass);
    add_row(2, "fill_alu", 6, 0, mode_until_full, kind_fill);
    add_row(3, "fill_mul", 0, 6, mode_until_full, kind_fill);
    add_row(4, "stream", 20, 20, mode_random, kind_stream);
    add_row(5, "stream_long", 30, 25, mode_random, kind_stream);
    total = 0;
    for (int i = 0; i < num_tests; i++) total += alu_items[i] + mul_items[i];
    timeout_cycles = total * 20 + 200;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < num_tests; i++) run_row(i);
    checker_i.report();
    if (checker_i.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
